//--- bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len = 68;

word_t prog [prog_len];

// one word per program slot at index (pc - reset_pc) / 4
task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
        prog[i] = enc_2ri12(op_andi, 0, 0, 0);
    end
    // register and immediate operations
    prog[0]  = enc_2ri12(op_addi_w, 1, 0, 12'h123);
    prog[1]  = enc_2ri12(op_addi_w, 2, 0, -1);
    prog[2]  = enc_3r(op_add_w, 3, 1, 2);
    prog[3]  = enc_3r(op_sub_w, 4, 1, 2);
    prog[4]  = enc_3r(op_slt, 5, 2, 1);
    prog[5]  = enc_3r(op_sltu, 6, 2, 1);
    prog[6]  = enc_3r(op_nor, 7, 1, 0);
    prog[7]  = enc_3r(op_and, 8, 1, 2);
    prog[8]  = enc_3r(op_or, 9, 1, 0);
    prog[9]  = enc_3r(op_xor, 10, 1, 2);
    prog[10] = enc_1ri20(op_lu12i_w, 11, 20'h80000);
    prog[11] = enc_3r(op_sra_w, 12, 11, 1);
    prog[12] = enc_3r(op_srl_w, 13, 11, 1);
    prog[13] = enc_3r(op_sll_w, 14, 1, 1);
    prog[14] = enc_3r(op_slli_w, 15, 1, 4);
    prog[15] = enc_3r(op_srli_w, 16, 11, 31);
    prog[16] = enc_3r(op_srai_w, 17, 11, 4);
    prog[17] = enc_2ri12(op_slti, 18, 2, 0);
    prog[18] = enc_2ri12(op_sltiu, 19, 1, -1);
    prog[19] = enc_2ri12(op_andi, 20, 2, 12'hf0f);
    prog[20] = enc_2ri12(op_ori, 21, 1, 12'h800);
    prog[21] = enc_2ri12(op_xori, 22, 2, 12'h0ff);
    prog[22] = enc_1ri20(op_pcaddu12i, 23, 1);
    // dependency chain
    prog[23] = enc_2ri12(op_addi_w, 24, 0, 10);
    prog[24] = enc_3r(op_add_w, 24, 24, 24);
    prog[25] = enc_3r(op_add_w, 24, 24, 1);
    prog[26] = enc_3r(op_sub_w, 25, 24, 24);
    prog[27] = enc_2ri12(op_addi_w, 25, 25, -3);
    // stores, loads and load-use
    prog[28] = enc_2ri12(op_addi_w, 26, 0, 12'h040);
    prog[29] = enc_2ri12(op_st_w, 1, 26, 0);
    prog[30] = enc_2ri12(op_st_w, 25, 26, 4);
    prog[31] = enc_2ri12(op_ld_w, 27, 26, 0);
    prog[32] = enc_3r(op_add_w, 28, 27, 27);
    prog[33] = enc_2ri12(op_ld_w, 29, 26, 4);
    prog[34] = enc_2ri12(op_addi_w, 29, 29, 3);
    // r0 stays zero
    prog[35] = enc_2ri12(op_addi_w, 0, 0, 12'h055);
    prog[36] = enc_3r(op_add_w, 30, 0, 1);
    // each conditional branch not taken, then taken over a marker
    prog[37] = enc_br(op_beq, 1, 2, 2);
    prog[38] = enc_2ri12(op_addi_w, 31, 0, 1);
    prog[39] = enc_br(op_beq, 1, 8, 2);
    prog[40] = enc_2ri12(op_addi_w, 31, 0, 12'h7ff);
    prog[41] = enc_br(op_bne, 1, 8, 2);
    prog[42] = enc_2ri12(op_addi_w, 31, 0, 2);
    prog[43] = enc_br(op_bne, 1, 2, 2);
    prog[44] = enc_2ri12(op_addi_w, 31, 0, 12'h7ff);
    prog[45] = enc_br(op_blt, 1, 2, 2);
    prog[46] = enc_2ri12(op_addi_w, 31, 0, 3);
    prog[47] = enc_br(op_blt, 2, 1, 2);
    prog[48] = enc_2ri12(op_addi_w, 31, 0, 12'h7ff);
    prog[49] = enc_br(op_bge, 2, 1, 2);
    prog[50] = enc_2ri12(op_addi_w, 31, 0, 4);
    prog[51] = enc_br(op_bge, 1, 2, 2);
    prog[52] = enc_2ri12(op_addi_w, 31, 0, 12'h7ff);
    prog[53] = enc_br(op_bltu, 2, 1, 2);
    prog[54] = enc_2ri12(op_addi_w, 31, 0, 5);
    prog[55] = enc_br(op_bltu, 1, 2, 2);
    prog[56] = enc_2ri12(op_addi_w, 31, 0, 12'h7ff);
    prog[57] = enc_br(op_bgeu, 1, 2, 2);
    prog[58] = enc_2ri12(op_addi_w, 31, 0, 6);
    prog[59] = enc_br(op_bgeu, 2, 1, 2);
    prog[60] = enc_2ri12(op_addi_w, 31, 0, 12'h7ff);
    prog[61] = enc_jump(op_b, 2);
    prog[62] = enc_2ri12(op_addi_w, 31, 0, 12'h7ff);
    // call and return
    prog[63] = enc_jump(op_bl, 3);
    prog[64] = enc_2ri12(op_addi_w, 31, 0, 7);
    prog[65] = enc_jump(op_b, 0);
    prog[66] = enc_2ri12(op_addi_w, 31, 0, 8);
    prog[67] = enc_br(op_jirl, 1, 0, 0);
endtask

// expected writebacks in order as program slot, register and value
task automatic load_expected();
    expect_write(0, 1, 32'h00000123);
    expect_write(1, 2, 32'hffffffff);
    expect_write(2, 3, 32'h00000122);
    expect_write(3, 4, 32'h00000124);
    expect_write(4, 5, 32'h00000001);
    expect_write(5, 6, 32'h00000000);
    expect_write(6, 7, 32'hfffffedc);
    expect_write(7, 8, 32'h00000123);
    expect_write(8, 9, 32'h00000123);
    expect_write(9, 10, 32'hfffffedc);
    expect_write(10, 11, 32'h80000000);
    expect_write(11, 12, 32'hf0000000);
    expect_write(12, 13, 32'h10000000);
    expect_write(13, 14, 32'h00000918);
    expect_write(14, 15, 32'h00001230);
    expect_write(15, 16, 32'h00000001);
    expect_write(16, 17, 32'hf8000000);
    expect_write(17, 18, 32'h00000001);
    expect_write(18, 19, 32'h00000001);
    expect_write(19, 20, 32'h00000f0f);
    expect_write(20, 21, 32'h00000923);
    expect_write(21, 22, 32'hffffff00);
    expect_write(22, 23, pc_of(22) + 32'h00001000);
    expect_write(23, 24, 32'h0000000a);
    expect_write(24, 24, 32'h00000014);
    expect_write(25, 24, 32'h00000137);
    expect_write(26, 25, 32'h00000000);
    expect_write(27, 25, 32'hfffffffd);
    expect_write(28, 26, 32'h00000040);
    expect_write(31, 27, 32'h00000123);
    expect_write(32, 28, 32'h00000246);
    expect_write(33, 29, 32'hfffffffd);
    expect_write(34, 29, 32'h00000000);
    expect_write(35, 0, 32'h00000055);
    expect_write(36, 30, 32'h00000123);
    expect_write(38, 31, 32'h00000001);
    expect_write(42, 31, 32'h00000002);
    expect_write(46, 31, 32'h00000003);
    expect_write(50, 31, 32'h00000004);
    expect_write(54, 31, 32'h00000005);
    expect_write(58, 31, 32'h00000006);
    expect_write(63, 1, pc_of(64));
    expect_write(66, 31, 32'h00000008);
    expect_write(67, 0, pc_of(68));
    expect_write(64, 31, 32'h00000007);
endtask

`endif

//--- bench/tb_cpu.sv
module tb_cpu import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // away from the core's default so the parameter has to reach fetch
    localparam word_t reset_pc = 32'h1c010000;

    logic      clk;
    logic      reset;
    sram_req_t inst_sram;
    word_t     inst_sram_rdata;
    sram_req_t data_sram;
    word_t     data_sram_rdata;
    wb_trace_t trace;

    word_t     dmem [64];
    word_t     exp_pc [$];
    reg_addr_t exp_num [$];
    word_t     exp_data [$];
    int        errors;

    function automatic word_t enc_3r(logic [16:0] op, int rd, int rj, int rk);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t enc_2ri12(logic [9:0] op, int rd, int rj, int imm);
        return {op, 12'(imm), 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t enc_1ri20(logic [6:0] op, int rd, int imm);
        return {op, 20'(imm), 5'(rd)};
    endfunction

    // conditional branches and jirl take an offset in words
    function automatic word_t enc_br(logic [5:0] op, int rj, int rd, int offs);
        return {op, 16'(offs), 5'(rj), 5'(rd)};
    endfunction

    // b and bl put offset bits 25:16 in the low ten bits
    function automatic word_t enc_jump(logic [5:0] op, int offs);
        logic [25:0] o;
        o = 26'(offs);
        return {op, o[15:0], o[25:16]};
    endfunction

    function automatic word_t pc_of(int idx);
        return reset_pc + 32'(4 * idx);
    endfunction

    task automatic expect_write(int idx, int rd, word_t value);
        exp_pc.push_back(pc_of(idx));
        exp_num.push_back(5'(rd));
        exp_data.push_back(value);
    endtask

    `include "tb_program.svh"

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic word_t fetch_word(word_t addr);
        word_t idx;
        idx = (addr - reset_pc) >> 2;
        if (idx < prog_len) begin
            return prog[idx];
        end
        return enc_2ri12(op_andi, 0, 0, 0);
    endfunction

    cpu_top #(
        .reset_pc (reset_pc)
    ) u_dut (
        .clk             (clk),
        .reset           (reset),
        .inst_sram       (inst_sram),
        .inst_sram_rdata (inst_sram_rdata),
        .data_sram       (data_sram),
        .data_sram_rdata (data_sram_rdata),
        .trace           (trace)
    );

    always #10 clk = ~clk;

    // both memories answer one clock after the request
    always @(posedge clk) begin
        if (inst_sram.en) begin
            inst_sram_rdata <= fetch_word(inst_sram.addr);
        end
        if (data_sram.en) begin
            if (data_sram.we != 4'h0) begin
                // only the enabled byte lanes change
                for (int b = 0; b < 4; b++) begin
                    if (data_sram.we[b]) begin
                        dmem[data_sram.addr[7:2]][8*b +: 8] <= data_sram.wdata[8*b +: 8];
                    end
                end
            end else begin
                data_sram_rdata <= dmem[data_sram.addr[7:2]];
            end
        end
    end

    initial begin
        int cycles;
        int limit;
        int n;
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        errors          = 0;
        n               = 0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = '0;
        end
        load_program();
        load_expected();
        limit  = 10 + 8 * prog_len;
        cycles = 10;

        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("reset trace rf_we", 32'h0, 32'(trace.rf_we));
        end
        @(posedge clk);
        reset <= 1'b0;

        while (n < exp_pc.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (trace.rf_we != 4'h0) begin
                check_value($sformatf("trace %0d pc", n), exp_pc[n], trace.pc);
                check_value($sformatf("trace %0d wnum", n), 32'(exp_num[n]),
                            32'(trace.rf_wnum));
                check_value($sformatf("trace %0d wdata", n), exp_data[n], trace.rf_wdata);
                n++;
            end
        end

        if (n < exp_pc.size()) begin
            $display("Timeout: the trace stopped after %0d of %0d expected writes",
                     n, exp_pc.size());
            errors++;
        end

        $display("%0d errors in %0d checked trace writes", errors, n);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- common/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // 3r format, bits 31:15 (the shift-immediates live here too)
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_sll_w  = 17'h0002e;
    localparam logic [16:0] op_srl_w  = 17'h0002f;
    localparam logic [16:0] op_sra_w  = 17'h00030;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // 2ri12 format, bits 31:22
    localparam logic [9:0] op_slti   = 10'h008;
    localparam logic [9:0] op_sltiu  = 10'h009;
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_andi   = 10'h00d;
    localparam logic [9:0] op_ori    = 10'h00e;
    localparam logic [9:0] op_xori   = 10'h00f;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // 1ri20 format, bits 31:25
    localparam logic [6:0] op_lu12i_w   = 7'h0a;
    localparam logic [6:0] op_pcaddu12i = 7'h0e;

    // 2ri16 format, bits 31:26
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;
    localparam logic [5:0] op_blt  = 6'h18;
    localparam logic [5:0] op_bge  = 6'h19;
    localparam logic [5:0] op_bltu = 6'h1a;
    localparam logic [5:0] op_bgeu = 6'h1b;

    typedef struct packed {
        logic [16:0] op;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] imm;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] imm;
        reg_addr_t   rd;
    } fmt_1ri20_t;

    // b and bl take {rj, rd, offs} as a 26-bit offset
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri16_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
        fmt_2ri16_t fmt_2ri16;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef struct packed {
        logic       en;
        logic [3:0] we;
        word_t      addr;
        word_t      wdata;
    } sram_req_t;

    typedef struct packed {
        word_t      pc;
        logic [3:0] rf_we;
        reg_addr_t  rf_wnum;
        word_t      rf_wdata;
    } wb_trace_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        reg_addr_t dest;
        logic      gr_we;
        logic      is_load;
        logic      is_store;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
        logic      gr_we;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_addr_t dest;
        logic      gr_we;
        logic      is_load;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        logic      gr_we;
        reg_addr_t dest;
        word_t     value;
        logic      is_load;
    } fwd_t;

endpackage

//--- compile.f
+incdir+bench
common/cpu_pkg.sv
hdl/fetch_stage.sv
decode/regfile.sv
decode/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu_top.sv
bench/tb_cpu.sv

//--- decode/decode_stage.sv
module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      valid_in,
    input  word_t     pc_in,
    input  word_t     inst,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  fwd_t      ex_fwd,
    input  fwd_t      mem_fwd,
    input  fwd_t      wb_fwd,
    input  logic      allowin_ex,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    output logic      allowin,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      valid_out,
    output id_ex_t    id_ex
);

    logic    valid;
    word_t   pc;
    logic    held;
    word_t   inst_q;
    inst_u   ins;
    logic    r3_hit;
    alu_op_e r3_op;
    logic    i12_hit;
    alu_op_e i12_op;
    logic    shift_imm;
    logic    reg_op;
    logic    zext_imm;
    logic    is_load;
    logic    is_store;
    logic    is_lu12i;
    logic    is_pcadd;
    logic    is_jirl;
    logic    is_b;
    logic    is_bl;
    logic    is_cond_br;
    logic    src_rd;
    logic    use_rj;
    logic    use_r2;
    logic    gr_we;
    logic    stall;
    logic    taken;
    word_t   imm;
    word_t   rj_value;
    word_t   rkd_value;
    word_t   off16;
    word_t   off26;

    function automatic logic fwd_hit(fwd_t f, reg_addr_t r);
        return f.valid && f.gr_we && (f.dest == r) && (r != '0);
    endfunction

    // youngest writer wins
    function automatic word_t fwd_pick(reg_addr_t r, word_t rf, fwd_t ex_f,
                                       fwd_t mem_f, fwd_t wb_f);
        if (fwd_hit(ex_f, r)) begin
            return ex_f.value;
        end else if (fwd_hit(mem_f, r)) begin
            return mem_f.value;
        end else if (fwd_hit(wb_f, r)) begin
            return wb_f.value;
        end
        return rf;
    endfunction

    function automatic logic load_hit(reg_addr_t r, fwd_t ex_f, fwd_t mem_f);
        if (fwd_hit(ex_f, r)) begin
            return ex_f.is_load;
        end
        return fwd_hit(mem_f, r) && mem_f.is_load;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            held  <= 1'b0;
        end else begin
            if (allowin) begin
                valid <= valid_in;
            end
            held <= !allowin;
        end
    end

    // sram output moves on while stalled, so keep a copy
    always_ff @(posedge clk) begin
        if (allowin) begin
            pc <= pc_in;
        end
        if (!held) begin
            inst_q <= inst;
        end
    end

    assign ins = held ? inst_q : inst;

    always_comb begin
        r3_hit = 1'b1;
        case (ins.fmt_3r.op)
            op_add_w:  r3_op = alu_add;
            op_sub_w:  r3_op = alu_sub;
            op_slt:    r3_op = alu_slt;
            op_sltu:   r3_op = alu_sltu;
            op_nor:    r3_op = alu_nor;
            op_and:    r3_op = alu_and;
            op_or:     r3_op = alu_or;
            op_xor:    r3_op = alu_xor;
            op_sll_w,
            op_slli_w: r3_op = alu_sll;
            op_srl_w,
            op_srli_w: r3_op = alu_srl;
            op_sra_w,
            op_srai_w: r3_op = alu_sra;
            default: begin
                r3_op  = alu_add;
                r3_hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        i12_hit = 1'b1;
        case (ins.fmt_2ri12.op)
            op_slti:  i12_op = alu_slt;
            op_sltiu: i12_op = alu_sltu;
            op_andi:  i12_op = alu_and;
            op_ori:   i12_op = alu_or;
            op_xori:  i12_op = alu_xor;
            op_addi_w,
            op_ld_w,
            op_st_w:  i12_op = alu_add;
            default: begin
                i12_op  = alu_add;
                i12_hit = 1'b0;
            end
        endcase
    end

    assign shift_imm  = ins.fmt_3r.op inside {op_slli_w, op_srli_w, op_srai_w};
    assign reg_op     = r3_hit && !shift_imm;
    assign zext_imm   = ins.fmt_2ri12.op inside {op_andi, op_ori, op_xori};
    assign is_load    = ins.fmt_2ri12.op == op_ld_w;
    assign is_store   = ins.fmt_2ri12.op == op_st_w;
    assign is_lu12i   = ins.fmt_1ri20.op == op_lu12i_w;
    assign is_pcadd   = ins.fmt_1ri20.op == op_pcaddu12i;
    assign is_jirl    = ins.fmt_2ri16.op == op_jirl;
    assign is_b       = ins.fmt_2ri16.op == op_b;
    assign is_bl      = ins.fmt_2ri16.op == op_bl;
    assign is_cond_br = ins.fmt_2ri16.op inside {op_beq, op_bne, op_blt, op_bge,
                                                 op_bltu, op_bgeu};

    // stores and conditional branches read rd on port 2
    assign src_rd = is_store || is_cond_br;
    assign use_rj = r3_hit || i12_hit || is_jirl || is_cond_br;
    assign use_r2 = reg_op || src_rd;
    assign gr_we  = r3_hit || (i12_hit && !is_store) || is_lu12i || is_pcadd
                    || is_bl || is_jirl;

    assign rf_raddr1 = ins.fmt_3r.rj;
    assign rf_raddr2 = src_rd ? ins.fmt_3r.rd : ins.fmt_3r.rk;
    assign rj_value  = fwd_pick(rf_raddr1, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign rkd_value = fwd_pick(rf_raddr2, rf_rdata2, ex_fwd, mem_fwd, wb_fwd);

    // load data only exists once the load is in writeback
    assign stall = (use_rj && load_hit(rf_raddr1, ex_fwd, mem_fwd))
                   || (use_r2 && load_hit(rf_raddr2, ex_fwd, mem_fwd));

    always_comb begin
        if (is_bl || is_jirl) begin
            imm = 32'd4;
        end else if (is_lu12i || is_pcadd) begin
            imm = {ins.fmt_1ri20.imm, 12'b0};
        end else if (zext_imm) begin
            imm = {20'b0, ins.fmt_2ri12.imm};
        end else begin
            imm = {{20{ins.fmt_2ri12.imm[11]}}, ins.fmt_2ri12.imm};
        end
    end

    always_comb begin
        case (ins.fmt_2ri16.op)
            op_beq:  taken = rj_value == rkd_value;
            op_bne:  taken = rj_value != rkd_value;
            op_blt:  taken = $signed(rj_value) < $signed(rkd_value);
            op_bge:  taken = $signed(rj_value) >= $signed(rkd_value);
            op_bltu: taken = rj_value < rkd_value;
            op_bgeu: taken = rj_value >= rkd_value;
            op_b,
            op_bl,
            op_jirl: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign off16 = {{14{ins.fmt_2ri16.offs[15]}}, ins.fmt_2ri16.offs, 2'b00};
    assign off26 = {{4{ins.fmt_2ri16.rj[4]}}, ins.fmt_2ri16.rj, ins.fmt_2ri16.rd,
                    ins.fmt_2ri16.offs, 2'b00};

    assign redirect_pc = is_jirl ? rj_value + off16
                                 : pc + ((is_b || is_bl) ? off26 : off16);

    assign valid_out = valid && !stall;
    assign allowin   = !valid || (!stall && allowin_ex);
    assign redirect  = valid && !stall && allowin_ex && taken;

    always_comb begin
        id_ex.pc         = pc;
        id_ex.alu_op     = r3_hit ? r3_op : (i12_hit ? i12_op : (is_lu12i ? alu_lui : alu_add));
        id_ex.src1       = (is_jirl || is_bl || is_pcadd) ? pc : rj_value;
        id_ex.src2       = reg_op ? rkd_value : imm;
        id_ex.store_data = rkd_value;
        id_ex.dest       = is_bl ? 5'd1 : ins.fmt_3r.rd;
        id_ex.gr_we      = gr_we;
        id_ex.is_load    = is_load;
        id_ex.is_store   = is_store;
    end

endmodule

//--- decode/regfile.sv
module regfile import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, whatever was written to it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/cpu_top.sv
module cpu_top import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'h1c000000
) (
    input  logic      clk,
    input  logic      reset,
    output sram_req_t inst_sram,
    input  word_t     inst_sram_rdata,
    output sram_req_t data_sram,
    input  word_t     data_sram_rdata,
    output wb_trace_t trace
);

    logic      if_valid;
    word_t     if_pc;
    logic      id_allowin;
    logic      redirect;
    word_t     redirect_pc;
    logic      id_valid;
    id_ex_t    id_ex;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      ex_allowin;
    logic      ex_valid;
    ex_mem_t   ex_mem;
    fwd_t      ex_fwd;
    logic      mem_allowin;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .allowin_id  (id_allowin),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_sram   (inst_sram),
        .valid       (if_valid),
        .pc          (if_pc)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .valid_in    (if_valid),
        .pc_in       (if_pc),
        .inst        (inst_sram_rdata),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .allowin_ex  (ex_allowin),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .allowin     (id_allowin),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .valid_out   (id_valid),
        .id_ex       (id_ex)
    );

    // writeback side of the trace drives the file write port
    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (|trace.rf_we),
        .waddr  (trace.rf_wnum),
        .wdata  (trace.rf_wdata)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .valid_in    (id_valid),
        .id_ex       (id_ex),
        .allowin_mem (mem_allowin),
        .allowin     (ex_allowin),
        .valid_out   (ex_valid),
        .ex_mem      (ex_mem),
        .fwd         (ex_fwd)
    );

    mem_wb_stage u_mem_wb (
        .clk             (clk),
        .reset           (reset),
        .valid_in        (ex_valid),
        .ex_mem          (ex_mem),
        .data_sram       (data_sram),
        .data_sram_rdata (data_sram_rdata),
        .allowin         (mem_allowin),
        .mem_fwd         (mem_fwd),
        .wb_fwd          (wb_fwd),
        .trace           (trace)
    );

endmodule

//--- hdl/execute_stage.sv
module execute_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    valid_in,
    input  id_ex_t  id_ex,
    input  logic    allowin_mem,
    output logic    allowin,
    output logic    valid_out,
    output ex_mem_t ex_mem,
    output fwd_t    fwd
);

    logic   valid;
    id_ex_t ex_q;
    word_t  result;

    assign allowin   = !valid || allowin_mem;
    assign valid_out = valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (allowin) begin
            ex_q <= id_ex;
        end
    end

    // shifts use only the low five bits of src2
    always_comb begin
        case (ex_q.alu_op)
            alu_add:  result = ex_q.src1 + ex_q.src2;
            alu_sub:  result = ex_q.src1 - ex_q.src2;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(ex_q.src1) < $signed(ex_q.src2)};
            alu_sltu: result = {{(xlen-1){1'b0}}, ex_q.src1 < ex_q.src2};
            alu_and:  result = ex_q.src1 & ex_q.src2;
            alu_nor:  result = ~(ex_q.src1 | ex_q.src2);
            alu_or:   result = ex_q.src1 | ex_q.src2;
            alu_xor:  result = ex_q.src1 ^ ex_q.src2;
            alu_sll:  result = ex_q.src1 << ex_q.src2[4:0];
            alu_srl:  result = ex_q.src1 >> ex_q.src2[4:0];
            alu_sra:  result = $signed(ex_q.src1) >>> ex_q.src2[4:0];
            alu_lui:  result = ex_q.src2;
            default:  result = ex_q.src1 + ex_q.src2;
        endcase
    end

    // result is also the load/store address
    always_comb begin
        ex_mem.pc         = ex_q.pc;
        ex_mem.result     = result;
        ex_mem.store_data = ex_q.store_data;
        ex_mem.dest       = ex_q.dest;
        ex_mem.gr_we      = ex_q.gr_we;
        ex_mem.is_load    = ex_q.is_load;
        ex_mem.is_store   = ex_q.is_store;
    end

    always_comb begin
        fwd.valid   = valid;
        fwd.gr_we   = ex_q.gr_we;
        fwd.dest    = ex_q.dest;
        fwd.value   = result;
        fwd.is_load = ex_q.is_load;
    end

endmodule

//--- hdl/fetch_stage.sv
module fetch_stage import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'h1c000000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      allowin_id,
    input  logic      redirect,
    input  word_t     redirect_pc,
    output sram_req_t inst_sram,
    output logic      valid,
    output word_t     pc
);

    word_t fetch_pc;

    // a word is requested only when decode takes it next cycle
    always_comb begin
        inst_sram.en    = allowin_id;
        inst_sram.we    = 4'h0;
        inst_sram.addr  = fetch_pc;
        inst_sram.wdata = '0;
    end

    // the request going out beside a taken branch is wrong path
    assign valid = allowin_id && !redirect;
    assign pc    = fetch_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= reset_pc;
        end else if (allowin_id) begin
            if (redirect) begin
                fetch_pc <= redirect_pc;
            end else begin
                fetch_pc <= fetch_pc + 32'd4;
            end
        end
    end

endmodule

//--- hdl/mem_wb_stage.sv
module mem_wb_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      valid_in,
    input  ex_mem_t   ex_mem,
    output sram_req_t data_sram,
    input  word_t     data_sram_rdata,
    output logic      allowin,
    output fwd_t      mem_fwd,
    output fwd_t      wb_fwd,
    output wb_trace_t trace
);

    logic    mem_valid;
    logic    wb_valid;
    ex_mem_t mem_q;
    mem_wb_t wb_q;
    word_t   wb_value;

    // writeback retires every cycle, so nothing ever backs up here
    assign allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            mem_valid <= valid_in;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_q        <= ex_mem;
        wb_q.pc      <= mem_q.pc;
        wb_q.result  <= mem_q.result;
        wb_q.dest    <= mem_q.dest;
        wb_q.gr_we   <= mem_q.gr_we;
        wb_q.is_load <= mem_q.is_load;
    end

    always_comb begin
        data_sram.en    = mem_valid && (mem_q.is_load || mem_q.is_store);
        data_sram.we    = (mem_valid && mem_q.is_store) ? 4'hf : 4'h0;
        data_sram.addr  = {mem_q.result[xlen-1:2], 2'b00};
        data_sram.wdata = mem_q.store_data;
    end

    // read data lands while the load sits in writeback
    assign wb_value = wb_q.is_load ? data_sram_rdata : wb_q.result;

    always_comb begin
        mem_fwd.valid    = mem_valid;
        mem_fwd.gr_we    = mem_q.gr_we;
        mem_fwd.dest     = mem_q.dest;
        mem_fwd.value    = mem_q.result;
        mem_fwd.is_load  = mem_q.is_load;
        wb_fwd.valid     = wb_valid;
        wb_fwd.gr_we     = wb_q.gr_we;
        wb_fwd.dest      = wb_q.dest;
        wb_fwd.value     = wb_value;
        wb_fwd.is_load   = wb_q.is_load;
        trace.pc         = wb_q.pc;
        trace.rf_we      = {4{wb_valid && wb_q.gr_we}};
        trace.rf_wnum    = wb_q.dest;
        trace.rf_wdata   = wb_value;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f compile.f \
    -o tb_cpu_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log

grep -qx "All checks passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
